// ==== hw/lspPkg.sv ====
package lspPkg;

	////////////////////////////////////////////////////////////
	// Data widths
	////////////////////////////////////////////////////////////

	typedef logic signed [15:0] word16_t;   // Fixed-point coefficient
	typedef logic signed [31:0] word32_t;   // Memory word and long operands
	typedef logic [11:0] memAddr_t;         // Bank in [11:4], index in [3:0]
	typedef logic [3:0] gapWidth_t;         // Zero-extended before use
	typedef logic [3:0] loopIdx_t;          // Loop index j

	// Sequencer states, one per step of the expansion loop
	typedef enum logic [2:0]
	{
		idle,        // Waiting for start
		loopTest,    // j < lpcOrder check, issue read of buf[j-1]
		readPrev,    // Latch buf[j-1], issue read of buf[j]
		computeTmp,  // Latch buf[j], form tmp
		writePrev,   // buf[j-1] - tmp
		writeNext    // buf[j] + tmp
	} lspState_t;

	////////////////////////////////////////////////////////////
	// Saturation limits
	////////////////////////////////////////////////////////////

	localparam word16_t WORD_MAX = 16'sh7FFF;   // +32767
	localparam word16_t WORD_MIN = 16'sh8000;   // -32768

	////////////////////////////////////////////////////////////
	// Loop constants
	////////////////////////////////////////////////////////////

	localparam loopIdx_t LOOP_FIRST = 4'd1;     // First j of the loop
	localparam word16_t INDEX_STEP = 16'sd1;    // j-1 and j+1
	localparam word16_t TMP_SHIFT = 16'sd1;     // Halving of diff + gap

endpackage

// ==== hw/basicOps.sv ====
`timescale 1ns/1ps

module basicOps
	import lspPkg::*;
(
	input  word16_t subA,
	input  word16_t subB,
	output word16_t subResult,
	input  word16_t addA,
	input  word16_t addB,
	output word16_t addResult,
	input  word16_t shrValue,
	input  word16_t shrAmount,
	output word16_t shrResult,
	input  word32_t lSubA,
	input  word32_t lSubB,
	output word32_t lSubResult,
	input  word32_t lAddA,
	input  word32_t lAddB,
	output word32_t lAddResult
);

	localparam word32_t LWORD_MAX = 32'sh7FFF_FFFF;
	localparam word32_t LWORD_MIN = 32'sh8000_0000;

	logic [16:0] subWide, addWide;     // One guard bit for overflow
	logic [32:0] lSubWide, lAddWide;

	////////////////////////////////////////////////////////////
	// 16-bit saturating add and sub
	////////////////////////////////////////////////////////////

	always_comb
	begin
		subWide = {subA[15], subA} - {subB[15], subB};
		if (subWide[16] != subWide[15])   // Guard and sign disagree
			subResult = subWide[16] ? WORD_MIN : WORD_MAX;
		else
			subResult = subWide[15:0];
	end

	always_comb
	begin
		addWide = {addA[15], addA} + {addB[15], addB};
		if (addWide[16] != addWide[15])
			addResult = addWide[16] ? WORD_MIN : WORD_MAX;
		else
			addResult = addWide[15:0];
	end

	// Arithmetic right shift
	always_comb
	begin
		if (shrAmount < 0)
			shrResult = shrValue;                   // Left shifts not used here
		else if (shrAmount >= 16'sd15)
			shrResult = {16{shrValue[15]}};         // Sign fill
		else
			shrResult = shrValue >>> shrAmount[3:0];
	end

	////////////////////////////////////////////////////////////
	// 32-bit saturating add and sub
	////////////////////////////////////////////////////////////

	always_comb
	begin
		lSubWide = {lSubA[31], lSubA} - {lSubB[31], lSubB};
		if (lSubWide[32] != lSubWide[31])
			lSubResult = lSubWide[32] ? LWORD_MIN : LWORD_MAX;
		else
			lSubResult = lSubWide[31:0];
	end

	always_comb
	begin
		lAddWide = {lAddA[31], lAddA} + {lAddB[31], lAddB};
		if (lAddWide[32] != lAddWide[31])
			lAddResult = lAddWide[32] ? LWORD_MIN : LWORD_MAX;
		else
			lAddResult = lAddWide[31:0];
	end

endmodule

// ==== hw/scratchMem.sv ====
`timescale 1ns/1ps

module scratchMem
	import lspPkg::*;
#(
	parameter int depth = 4096
)
(
	input  logic clk,
	input  memAddr_t readAddr,       // Port A, sequencer
	input  memAddr_t writeAddr,
	input  word32_t writeData,
	input  logic writeEn,
	output word32_t readData,
	input  memAddr_t hostAddr,       // Port B, host
	input  word32_t hostWriteData,
	input  logic hostWriteEn,
	output word32_t hostReadData
);

	word32_t mem [depth];   // Coefficient buffers, one bank per 16 words

	always_ff @(posedge clk)
	begin
		if (writeEn)
			mem[writeAddr] <= writeData;
		if (hostWriteEn)
			mem[hostAddr] <= hostWriteData;
		readData <= mem[readAddr];         // One-cycle registered reads
		hostReadData <= mem[hostAddr];
	end

	////////////////////////////////////////////////////////////
	// Host and sequencer must not collide on a write
	////////////////////////////////////////////////////////////

	assert property (@(posedge clk)
		!(writeEn && hostWriteEn && (writeAddr == hostAddr)));

endmodule

// ==== hw/lspExpandFsm.sv ====
`timescale 1ns/1ps

module lspExpandFsm
	import lspPkg::*;
#(
	parameter int lpcOrder = 10
)
(
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  memAddr_t bufAddr,
	input  gapWidth_t gap,
	input  word32_t readData,
	input  word16_t subResult,
	input  word16_t addResult,
	input  word16_t shrResult,
	input  word32_t lSubResult,
	input  word32_t lAddResult,
	output word16_t subA,
	output word16_t subB,
	output word16_t addA,
	output word16_t addB,
	output word16_t shrValue,
	output word16_t shrAmount,
	output word32_t lSubA,
	output word32_t lSubB,
	output word32_t lAddA,
	output word32_t lAddB,
	output memAddr_t readAddr,
	output memAddr_t writeAddr,
	output word32_t writeData,
	output logic writeEn,
	output logic done
);

	lspState_t state, nextState;
	loopIdx_t j, nextJ;
	logic jInit, jLoad;
	logic loopEnd, nextEnd;   // Set once the incremented j reaches lpcOrder
	logic prevLoad, curLoad, tmpLoad;
	word16_t bufPrev;         // buf[j-1]
	word16_t bufCur;          // buf[j]
	word16_t tmp;
	logic [7:0] bank;

	assign bank = bufAddr[11:4];   // Index bits come from j

	////////////////////////////////////////////////////////////
	// Control registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			j <= LOOP_FIRST;
			loopEnd <= 1'b0;
		end
		else
		begin
			state <= nextState;
			if (jInit)
			begin
				j <= LOOP_FIRST;
				loopEnd <= 1'b0;
			end
			else if (jLoad)
			begin
				j <= nextJ;
				loopEnd <= nextEnd;
			end
		end
	end

	// Operand latches
	always_ff @(posedge clk)
	begin
		if (prevLoad)
			bufPrev <= readData[15:0];
		if (curLoad)
			bufCur <= readData[15:0];
		if (tmpLoad)
			tmp <= shrResult;
	end

	////////////////////////////////////////////////////////////
	// Next state and datapath steering
	////////////////////////////////////////////////////////////

	always_comb
	begin
		nextState = state;
		nextJ = j;
		nextEnd = loopEnd;
		jInit = 1'b0;
		jLoad = 1'b0;
		prevLoad = 1'b0;
		curLoad = 1'b0;
		tmpLoad = 1'b0;
		subA = '0;   // Idle operands stay at zero
		subB = '0;
		addA = '0;
		addB = '0;
		shrValue = '0;
		shrAmount = '0;
		lSubA = '0;
		lSubB = '0;
		lAddA = '0;
		lAddB = '0;
		readAddr = '0;
		writeAddr = '0;
		writeData = '0;
		writeEn = 1'b0;
		done = 1'b0;

		case (state)
			idle:
			begin
				if (start)
				begin
					jInit = 1'b1;
					nextState = loopTest;
				end
			end
			loopTest:
			begin
				if (loopEnd)
				begin
					done = 1'b1;   // j reached lpcOrder
					nextState = idle;
				end
				else
				begin
					subA = {12'd0, j};   // j-1 through the shared sub
					subB = INDEX_STEP;
					readAddr = {bank, subResult[3:0]};
					nextState = readPrev;
				end
			end
			readPrev:
			begin
				prevLoad = 1'b1;
				readAddr = {bank, j};
				nextState = computeTmp;
			end
			computeTmp:
			begin
				curLoad = 1'b1;
				subA = bufPrev;               // diff = buf[j-1] - buf[j]
				subB = readData[15:0];
				addA = subResult;             // diff + gap
				addB = {12'd0, gap};
				shrValue = addResult;         // Halved
				shrAmount = TMP_SHIFT;
				tmpLoad = 1'b1;
				nextState = writePrev;
			end
			writePrev:
			begin
				if (!tmp[15])   // Zero counts as non-negative
				begin
					subA = bufPrev;
					subB = tmp;
					lSubA = {28'd0, j};   // Address of buf[j-1]
					lSubB = 32'sd1;
					writeAddr = {bank, lSubResult[3:0]};
					writeData = {16'd0, subResult};
					writeEn = 1'b1;
					nextState = writeNext;
				end
				else
				begin
					addA = {12'd0, j};   // Skip both writes, next j
					addB = INDEX_STEP;
					nextJ = addResult[3:0];
					nextEnd = (addResult >= lpcOrder);
					jLoad = 1'b1;
					nextState = loopTest;
				end
			end
			writeNext:
			begin
				addA = bufCur;
				addB = tmp;
				writeAddr = {bank, j};
				writeData = {16'd0, addResult};
				writeEn = 1'b1;
				lAddA = {28'd0, j};   // Increment on the long adder, short one is busy
				lAddB = 32'sd1;
				nextJ = lAddResult[3:0];
				nextEnd = (lAddResult >= lpcOrder);
				jLoad = 1'b1;
				nextState = loopTest;
			end
			default:
				nextState = idle;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// Memory strobe only from the write states, on buf[j-1] and then on buf[j]
	assert property (@(posedge clk) disable iff (reset)
		writeEn |-> ((state == writePrev) ? (writeAddr[3:0] == j - 4'd1)
			: ((state == writeNext) && (writeAddr[3:0] == j))));

	// Single-cycle done
	assert property (@(posedge clk) disable iff (reset) done |=> !done);

	// Loop body never runs past the last index
	assert property (@(posedge clk) disable iff (reset)
		(state inside {readPrev, computeTmp, writePrev, writeNext}) |-> (j < lpcOrder));

endmodule

// ==== hw/lspExpandTop.sv ====
`timescale 1ns/1ps

module lspExpandTop
	import lspPkg::*;
#(
	parameter int lpcOrder = 10
)
(
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  memAddr_t bufAddr,
	input  gapWidth_t gap,
	input  memAddr_t hostAddr,
	input  word32_t hostWriteData,
	input  logic hostWriteEn,
	output word32_t hostReadData,
	output logic done
);

	// Operator requests and results
	word16_t subA, subB, subResult;
	word16_t addA, addB, addResult;
	word16_t shrValue, shrAmount, shrResult;
	word32_t lSubA, lSubB, lSubResult;
	word32_t lAddA, lAddB, lAddResult;

	// Sequencer side of the memory
	memAddr_t readAddr, writeAddr;
	word32_t readData, writeData;
	logic writeEn;

	////////////////////////////////////////////////////////////
	// Decode, execute, result
	////////////////////////////////////////////////////////////

	lspExpandFsm #(
		.lpcOrder(lpcOrder)
	) fsm (
		.clk(clk),
		.reset(reset),
		.start(start),
		.bufAddr(bufAddr),
		.gap(gap),
		.readData(readData),
		.subResult(subResult),
		.addResult(addResult),
		.shrResult(shrResult),
		.lSubResult(lSubResult),
		.lAddResult(lAddResult),
		.subA(subA),
		.subB(subB),
		.addA(addA),
		.addB(addB),
		.shrValue(shrValue),
		.shrAmount(shrAmount),
		.lSubA(lSubA),
		.lSubB(lSubB),
		.lAddA(lAddA),
		.lAddB(lAddB),
		.readAddr(readAddr),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.writeEn(writeEn),
		.done(done)
	);

	basicOps ops (   // Zero-latency operator unit
		.subA(subA),
		.subB(subB),
		.subResult(subResult),
		.addA(addA),
		.addB(addB),
		.addResult(addResult),
		.shrValue(shrValue),
		.shrAmount(shrAmount),
		.shrResult(shrResult),
		.lSubA(lSubA),
		.lSubB(lSubB),
		.lSubResult(lSubResult),
		.lAddA(lAddA),
		.lAddB(lAddB),
		.lAddResult(lAddResult)
	);

	scratchMem #(
		.depth(1 << $bits(memAddr_t))   // Full 12-bit address space
	) mem (
		.clk(clk),
		.readAddr(readAddr),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.writeEn(writeEn),
		.readData(readData),
		.hostAddr(hostAddr),
		.hostWriteData(hostWriteData),
		.hostWriteEn(hostWriteEn),
		.hostReadData(hostReadData)
	);

endmodule

// ==== test/lspExpandTb.sv ====
`timescale 1ns/1ps

module lspExpandTb
	import lspPkg::*;
();

	localparam int ORDER = 10;
	localparam int DONE_TIMEOUT = 200;          // Cycles allowed from start to done
	localparam int LAT_MIN = 4 * (ORDER - 1) + 2;   // Every tmp negative
	localparam int LAT_MAX = 5 * (ORDER - 1) + 2;   // Every tmp non-negative
	localparam int QUIET = 12;                  // Idle window after done

	logic clk;
	logic reset;
	logic start;
	memAddr_t bufAddr;
	gapWidth_t gap;
	memAddr_t hostAddr;
	word32_t hostWriteData;
	logic hostWriteEn;
	word32_t hostReadData;
	logic done;

	word16_t loadBuf [16];    // Host image of the bank
	word16_t expBuf [16];     // Reference result
	word32_t expWords [16];
	word32_t gotWords [16];
	logic [7:0] compareBank;
	bit compareReq;
	int doneCount;
	int errors;
	int testErrors;
	int testsRun;
	int testsFailed;

	lspExpandTop #(
		.lpcOrder(ORDER)
	) uut (
		.clk(clk),
		.reset(reset),
		.start(start),
		.bufAddr(bufAddr),
		.gap(gap),
		.hostAddr(hostAddr),
		.hostWriteData(hostWriteData),
		.hostWriteEn(hostWriteEn),
		.hostReadData(hostReadData),
		.done(done)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;   // 8 ns period
	end

	always @(posedge clk)
		if (!reset && done)
			doneCount <= doneCount + 1;

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic int satAdd(input int a, input int b);
		int s;
		s = a + b;
		if (s > WORD_MAX)
			return WORD_MAX;
		if (s < WORD_MIN)
			return WORD_MIN;
		return s;
	endfunction

	function automatic int satSub(input int a, input int b);
		return satAdd(a, -b);   // -b stays in int range
	endfunction

	// One expansion pass over loadBuf, in place on expBuf
	function automatic void expandRef(input int g);
		int k;
		int t;
		for (k = 0; k < 16; k++)
			expBuf[k] = loadBuf[k];
		for (k = 1; k < ORDER; k++)
		begin
			t = satAdd(satSub(expBuf[k - 1], expBuf[k]), g);
			t = t >>> 1;
			if (t >= 0)   // Zero rewrites equal values
			begin
				expBuf[k - 1] = word16_t'(satSub(expBuf[k - 1], t));
				expBuf[k] = word16_t'(satAdd(expBuf[k], t));
			end
		end
	endfunction

	function automatic word32_t patternWord(input memAddr_t a);
		return {4'hC, a, 4'h5, ~a};
	endfunction

	// Compares the read-back bank on request
	initial
	begin
		int k;
		forever
		begin
			@(posedge clk);
			if (compareReq)
			begin
				for (k = 0; k < 16; k++)
				begin
					assert (gotWords[k] === expWords[k])
					else
					begin
						$display("** Error at %0t ns: hostReadData @ %h = %h, expected %h",
							$time, {compareBank, k[3:0]}, gotWords[k], expWords[k]);
						errors++;
						testErrors++;
					end
				end
				compareReq = 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Host port tasks
	////////////////////////////////////////////////////////////

	task automatic loadBank(input logic [7:0] bank);
		int k;
		for (k = 0; k < 16; k++)
		begin
			@(posedge clk);
			hostAddr <= {bank, k[3:0]};
			hostWriteData <= {16'd0, loadBuf[k]};
			hostWriteEn <= 1'b1;
		end
		@(posedge clk);
		hostWriteEn <= 1'b0;
	endtask

	task automatic fillPattern(input logic [7:0] bank);
		int k;
		for (k = 0; k < 16; k++)
		begin
			@(posedge clk);
			hostAddr <= {bank, k[3:0]};
			hostWriteData <= patternWord({bank, k[3:0]});
			hostWriteEn <= 1'b1;
		end
		@(posedge clk);
		hostWriteEn <= 1'b0;
	endtask

	task automatic readBank(input logic [7:0] bank);
		int k;
		for (k = 0; k < 16; k++)
		begin
			@(posedge clk);
			hostAddr <= {bank, k[3:0]};
			@(posedge clk);                 // Registered read
			@(negedge clk);
			gotWords[k] = hostReadData;
		end
	endtask

	task automatic compareWords(input logic [7:0] bank);
		int waited;
		compareBank = bank;
		compareReq = 1'b1;
		waited = 0;
		while (compareReq && waited < 4)
		begin
			@(negedge clk);
			waited++;
		end
		if (compareReq)
		begin
			$display("Comparison process did not answer within 4 cycles");
			errors++;
			testErrors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Start, wait for done, check the handshake
	////////////////////////////////////////////////////////////

	task automatic runExpand(input logic [7:0] bank, input gapWidth_t g, input int strayAt,
			output int cycles);
		int startDones;
		bit seen;
		startDones = doneCount;
		seen = 1'b0;
		cycles = 0;
		@(posedge clk);
		bufAddr <= {bank, 4'd0};
		gap <= g;
		start <= 1'b1;
		while (!seen && cycles < DONE_TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
			seen = done;
			@(posedge clk);
			start <= (cycles == strayAt);   // Optional stray start mid-run
		end
		if (!seen)
		begin
			$display("Timeout: done did not arrive within %0d cycles of start", DONE_TIMEOUT);
			errors++;
			testErrors++;
		end
		else
		begin
			assert (cycles >= LAT_MIN && cycles <= LAT_MAX)
			else
			begin
				$display("Latency of %0d cycles lies outside %0d to %0d", cycles, LAT_MIN, LAT_MAX);
				errors++;
				testErrors++;
			end
		end
		repeat (QUIET) @(negedge clk);
		assert (doneCount - startDones == 1)
		else
		begin
			$display("done pulsed %0d times for one start", doneCount - startDones);
			errors++;
			testErrors++;
		end
		assert (uut.fsm.state == idle)
		else
		begin
			$display("Sequencer did not return to idle after done");
			errors++;
			testErrors++;
		end
	endtask

	task automatic runCase(input logic [7:0] bank, input gapWidth_t g, input int strayAt,
			output int cycles);
		int k;
		loadBank(bank);
		expandRef(g);
		runExpand(bank, g, strayAt, cycles);
		readBank(bank);
		for (k = 0; k < 16; k++)
			expWords[k] = {16'd0, expBuf[k]};
		compareWords(bank);
	endtask

	task automatic checkLatency(input int cycles, input int expected);
		assert (cycles == expected)
		else
		begin
			$display("** Error at %0t ns: latency = %0d, expected %0d", $time, cycles, expected);
			errors++;
			testErrors++;
		end
	endtask

	task automatic endTest(input string name);
		testsRun++;
		if (testErrors == 0)
			$display("test %0d %s: ok", testsRun, name);
		else
		begin
			testsFailed++;
			$display("test %0d %s: FAIL, %0d errors", testsRun, name, testErrors);
		end
		testErrors = 0;
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		int k;
		int n;
		int cycles;
		logic [31:0] rnd;
		logic [7:0] bank;
		logic [7:0] patBank;
		reset = 1'b1;
		start = 1'b0;
		bufAddr = '0;
		gap = '0;
		hostAddr = '0;
		hostWriteData = '0;
		hostWriteEn = 1'b0;
		compareReq = 1'b0;
		doneCount = 0;
		errors = 0;
		testErrors = 0;
		testsRun = 0;
		testsFailed = 0;
		rnd = $urandom(7);
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		// Ascending, far apart, so every tmp is negative
		for (k = 0; k < 16; k++)
			loadBuf[k] = word16_t'(-30000 + 3000 * k);
		runCase(8'h03, 4'd8, 0, cycles);
		checkLatency(cycles, LAT_MIN);
		endTest("sorted wide buffer");

		// Pairs 3 apart inside a gap of 12
		for (k = 0; k < 16; k++)
			loadBuf[k] = word16_t'(-20000 + 3000 * (k >> 1) + 3 * (k & 1));
		runCase(8'h10, 4'd12, 0, cycles);
		endTest("close pairs");

		// Rails at both ends
		for (k = 0; k < 16; k++)
			loadBuf[k] = (k % 2 == 0) ? word16_t'(32767 - k) : word16_t'(-32768 + k);
		loadBuf[0] = WORD_MIN;   // Equal pairs on the rails push the updates past them
		loadBuf[1] = WORD_MIN;
		loadBuf[8] = WORD_MAX;
		loadBuf[9] = WORD_MAX;
		runCase(8'h7F, 4'd15, 0, cycles);
		endTest("saturation");

		for (k = 0; k < 16; k++)
			loadBuf[k] = word16_t'(400 + 6 * (k >> 1));   // Equal pairs, step 6
		runCase(8'h21, 4'd0, 0, cycles);
		runCase(8'h21, 4'd15, 0, cycles);
		endTest("gap 0 and gap 15");

		// Random banks, second bank guards against stray writes
		for (n = 0; n < 20; n++)
		begin
			rnd = $urandom;
			bank = rnd[7:0];
			patBank = bank + 8'd1;
			for (k = 0; k < 16; k++)
			begin
				loadBuf[k] = word16_t'($urandom);
			end
			fillPattern(patBank);
			runCase(bank, rnd[11:8], 0, cycles);
			readBank(patBank);
			for (k = 0; k < 16; k++)
				expWords[k] = patternWord({patBank, k[3:0]});
			compareWords(patBank);
		end
		endTest("random buffers");

		// Equal values write on every j, stray start at cycle 20
		for (k = 0; k < 16; k++)
			loadBuf[k] = 16'sd1234;
		runCase(8'h55, 4'd3, 20, cycles);
		checkLatency(cycles, LAT_MAX);
		endTest("handshake and latency");

		$display("tests run: %0d, failing tests: %0d, errors: %0d", testsRun, testsFailed, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== sources.f ====
hw/lspPkg.sv
hw/basicOps.sv
hw/scratchMem.sv
hw/lspExpandFsm.sv
hw/lspExpandTop.sv
test/lspExpandTb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = lspExpandTb
FILELIST = sources.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx 'Test passed' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
